// File: common/icache_cfg.svh
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// Instruction word width in bits
`define ICACHE_WORD_W 32

// Words per cache line
`define ICACHE_LINE_WORDS 8

// Number of lines, power of two
`define ICACHE_DEPTH 64

// Byte address width
`define ICACHE_ADDR_W 32

`endif

// File: common/icache_pkg.sv
`include "icache_cfg.svh"

package icache_pkg;

    localparam int WORD_W     = `ICACHE_WORD_W;
    localparam int LINE_WORDS = `ICACHE_LINE_WORDS;
    localparam int DEPTH      = `ICACHE_DEPTH;
    localparam int ADDR_W     = `ICACHE_ADDR_W;

    localparam int LINE_W     = WORD_W * LINE_WORDS;
    // Byte offset inside a line and inside a word
    localparam int OFFSET_W   = $clog2(LINE_W / 8);
    localparam int BYTE_SEL_W = $clog2(WORD_W / 8);
    localparam int WSEL_W     = $clog2(LINE_WORDS);
    localparam int INDEX_W    = $clog2(DEPTH);
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
    localparam int L2_ADDR_W  = ADDR_W - OFFSET_W;

    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [LINE_W-1:0]    line_t;
    typedef logic [INDEX_W-1:0]   index_t;
    typedef logic [OFFSET_W-1:0]  offset_t;
    typedef logic [TAG_W-1:0]     tag_t;
    typedef logic [L2_ADDR_W-1:0] l2_addr_t;

    typedef enum logic [0:0]
    {
        REFILL_IDLE,
        REFILL_WAIT
    } refill_state_t;

endpackage

// File: icache/icache_top.sv
`timescale 1ns/10ps

`include "icache_cfg.svh"

module icache_top
(
    input  logic                   CLK,
    input  logic                   RST,
    input  logic                   flush,
    input  icache_pkg::addr_t      addr,
    input  logic                   addr_valid,
    input  icache_pkg::line_t      fill_data,
    input  logic                   fill_valid,
    output icache_pkg::word_t      data,
    output logic                   cache_ready,
    output logic                   l2_req,
    output icache_pkg::l2_addr_t   l2_addr
);

    localparam int INDEX_LO = icache_pkg::OFFSET_W;
    localparam int INDEX_HI = icache_pkg::OFFSET_W + icache_pkg::INDEX_W - 1;

    logic                  hit;
    logic                  line_we;
    icache_pkg::index_t    line_index;
    icache_pkg::tag_t      line_tag;
    icache_pkg::line_t     line_data;
    icache_pkg::word_t     bank_word [`ICACHE_LINE_WORDS];

    refill_ctrl refill_ctrl_i
    (
        .CLK        (CLK),
        .RST        (RST),
        .addr       (addr),
        .addr_valid (addr_valid),
        .hit        (hit),
        .fill_data  (fill_data),
        .fill_valid (fill_valid),
        .l2_req     (l2_req),
        .l2_addr    (l2_addr),
        .line_we    (line_we),
        .line_index (line_index),
        .line_tag   (line_tag),
        .line_data  (line_data)
    );

    // One bank per word of the line, all written together on refill
    for (genvar k = 0; k < `ICACHE_LINE_WORDS; k++)
    begin : g_bank
        word_bank word_bank_i
        (
            .CLK    (CLK),
            .we     (line_we),
            .windex (line_index),
            .wdata  (line_data[k*icache_pkg::WORD_W +: icache_pkg::WORD_W]),
            .rindex (addr[INDEX_HI:INDEX_LO]),
            .rdata  (bank_word[k])
        );
    end

    lookup_unit lookup_unit_i
    (
        .CLK        (CLK),
        .RST        (RST),
        .flush      (flush),
        .addr       (addr),
        .line_we    (line_we),
        .line_index (line_index),
        .line_tag   (line_tag),
        .bank_word  (bank_word),
        .data       (data),
        .hit        (hit)
    );

    assign cache_ready = hit;

endmodule

// File: icache/lookup_unit.sv
`timescale 1ns/10ps

module lookup_unit
(
    input  logic                 CLK,
    input  logic                 RST,
    input  logic                 flush,
    input  icache_pkg::addr_t    addr,
    input  logic                 line_we,
    input  icache_pkg::index_t   line_index,
    input  icache_pkg::tag_t     line_tag,
    input  icache_pkg::word_t    bank_word [icache_pkg::LINE_WORDS],
    output icache_pkg::word_t    data,
    output logic                 hit
);

    localparam int OFFSET_W   = icache_pkg::OFFSET_W;
    localparam int INDEX_W    = icache_pkg::INDEX_W;
    localparam int ADDR_W     = icache_pkg::ADDR_W;
    localparam int BYTE_SEL_W = icache_pkg::BYTE_SEL_W;

    icache_pkg::tag_t               tags [icache_pkg::DEPTH];
    logic [icache_pkg::DEPTH-1:0]   valid;

    icache_pkg::offset_t            rd_offset;
    icache_pkg::index_t             rd_index;
    icache_pkg::tag_t               rd_tag;
    logic [icache_pkg::WSEL_W-1:0]  rd_wsel;

    assign rd_offset = addr[OFFSET_W - 1:0];
    assign rd_index  = addr[OFFSET_W + INDEX_W - 1:OFFSET_W];
    assign rd_tag    = addr[ADDR_W - 1:OFFSET_W + INDEX_W];
    assign rd_wsel   = rd_offset[OFFSET_W - 1:BYTE_SEL_W];

    always_ff @(posedge CLK)
    begin
        if (line_we)
        begin
            tags[line_index] <= line_tag;
        end
    end

    // Refill of a line beats a flush in the same cycle
    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            valid <= '0;
        end
        else
        begin
            if (flush)
            begin
                valid <= '0;
            end
            if (line_we)
            begin
                valid[line_index] <= 1'b1;
            end
        end
    end

    assign hit  = valid[rd_index] && (tags[rd_index] == rd_tag);

    // Word select from the offset
    assign data = bank_word[rd_wsel];

endmodule

// File: icache/refill_ctrl.sv
`timescale 1ns/10ps

module refill_ctrl
(
    input  logic                   CLK,
    input  logic                   RST,
    input  icache_pkg::addr_t      addr,
    input  logic                   addr_valid,
    input  logic                   hit,
    input  icache_pkg::line_t      fill_data,
    input  logic                   fill_valid,
    output logic                   l2_req,
    output icache_pkg::l2_addr_t   l2_addr,
    output logic                   line_we,
    output icache_pkg::index_t     line_index,
    output icache_pkg::tag_t       line_tag,
    output icache_pkg::line_t      line_data
);

    localparam int OFFSET_W = icache_pkg::OFFSET_W;
    localparam int INDEX_W  = icache_pkg::INDEX_W;
    localparam int ADDR_W   = icache_pkg::ADDR_W;

    icache_pkg::refill_state_t state;
    logic                      miss;
    icache_pkg::index_t        addr_index;
    icache_pkg::tag_t          addr_tag;

    assign addr_index = addr[OFFSET_W + INDEX_W - 1:OFFSET_W];
    assign addr_tag   = addr[ADDR_W - 1:OFFSET_W + INDEX_W];

    // Hold off while a refill write is still landing, hit is stale then
    assign miss = addr_valid && !hit && !line_we && (state == icache_pkg::REFILL_IDLE);

    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            state   <= icache_pkg::REFILL_IDLE;
            l2_req  <= 1'b0;
            line_we <= 1'b0;
        end
        else
        begin
            l2_req  <= 1'b0;
            line_we <= 1'b0;
            case (state)
                icache_pkg::REFILL_IDLE:
                begin
                    if (miss)
                    begin
                        l2_req <= 1'b1;
                        state  <= icache_pkg::REFILL_WAIT;
                    end
                end
                icache_pkg::REFILL_WAIT:
                begin
                    if (fill_valid)
                    begin
                        line_we <= 1'b1;
                        state   <= icache_pkg::REFILL_IDLE;
                    end
                end
                default:
                begin
                    state <= icache_pkg::REFILL_IDLE;
                end
            endcase
        end
    end

    // Line address, index and tag captured with the request
    always_ff @(posedge CLK)
    begin
        if (miss)
        begin
            l2_addr    <= addr[ADDR_W - 1:OFFSET_W];
            line_index <= addr_index;
            line_tag   <= addr_tag;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (fill_valid && state == icache_pkg::REFILL_WAIT)
        begin
            line_data <= fill_data;
        end
    end

endmodule

// File: icache/word_bank.sv
`timescale 1ns/10ps

module word_bank
(
    input  logic                 CLK,
    input  logic                 we,
    input  icache_pkg::index_t   windex,
    input  icache_pkg::word_t    wdata,
    input  icache_pkg::index_t   rindex,
    output icache_pkg::word_t    rdata
);

    // Word k of every line
    icache_pkg::word_t mem [icache_pkg::DEPTH];

    always_ff @(posedge CLK)
    begin
        if (we)
        begin
            mem[windex] <= wdata;
        end
    end

    // Asynchronous read
    assign rdata = mem[rindex];

endmodule

// File: sim.f
+incdir+common
common/icache_pkg.sv
icache/word_bank.sv
icache/lookup_unit.sv
icache/refill_ctrl.sv
icache/icache_top.sv
sim/icache_chk.sv
sim/icache_tb.sv

// File: sim/icache_chk.sv
`timescale 1ns/10ps

module icache_chk
(
    input  logic                        CLK,
    input  logic                        RST,
    input  logic                        l2_req,
    input  logic                        fill_valid,
    input  logic                        line_we,
    input  icache_pkg::refill_state_t   state
);

    int assert_fails = 0;

    // Request is a single-cycle strobe
    req_single: assert property (@(posedge CLK) disable iff (RST) l2_req |=> !l2_req)
    else
    begin
        $error("l2_req stayed high for two cycles");
        assert_fails++;
    end

    // Line write one cycle after the fill strobe
    we_after_fill: assert property (@(posedge CLK) disable iff (RST) fill_valid |=> line_we)
    else
    begin
        $error("line_we did not follow fill_valid");
        assert_fails++;
    end

    we_needs_fill: assert property (@(posedge CLK) disable iff (RST) line_we |-> $past(fill_valid))
    else
    begin
        $error("line_we without fill_valid one cycle before");
        assert_fails++;
    end

    // Nothing new goes out while a refill is pending
    no_req_in_wait: assert property (@(posedge CLK) disable iff (RST)
        state == icache_pkg::REFILL_WAIT |=> !l2_req)
    else
    begin
        $error("l2_req sent while refill pending");
        assert_fails++;
    end

endmodule

// File: sim/icache_tb.sv
`timescale 1ns/10ps

module icache_tb;

    typedef struct packed
    {
        icache_pkg::addr_t addr;
        logic              flush;
        logic              miss;
        logic              serve;
    } row_t;

    logic                  CLK;
    logic                  RST;
    logic                  flush;
    icache_pkg::addr_t     addr;
    logic                  addr_valid;
    icache_pkg::line_t     fill_data;
    logic                  fill_valid;
    icache_pkg::word_t     data;
    logic                  cache_ready;
    logic                  l2_req;
    icache_pkg::l2_addr_t  l2_addr;

    int                    seed;
    int                    errors;
    int                    timeouts;
    int                    req_count;
    logic                  l2_enable;
    row_t                  rows [$];

    icache_top icache_top_i
    (
        .CLK         (CLK),
        .RST         (RST),
        .flush       (flush),
        .addr        (addr),
        .addr_valid  (addr_valid),
        .fill_data   (fill_data),
        .fill_valid  (fill_valid),
        .data        (data),
        .cache_ready (cache_ready),
        .l2_req      (l2_req),
        .l2_addr     (l2_addr)
    );

    bind refill_ctrl icache_chk icache_chk_i
    (
        .CLK        (CLK),
        .RST        (RST),
        .l2_req     (l2_req),
        .fill_valid (fill_valid),
        .line_we    (line_we),
        .state      (state)
    );

    initial
    begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // Word k of line A is (A << 3 | k) ^ A5000000
    function automatic icache_pkg::word_t expected_word(input icache_pkg::addr_t a);
        icache_pkg::word_t base;
        icache_pkg::word_t k;
        base = icache_pkg::word_t'(a >> icache_pkg::OFFSET_W) << 3;
        k    = (a >> 2) & 32'h7;
        return (base | k) ^ 32'hA500_0000;
    endfunction

    function automatic icache_pkg::line_t model_line(input icache_pkg::l2_addr_t la);
        icache_pkg::line_t line;
        icache_pkg::word_t base;
        base = icache_pkg::word_t'(la) << 3;
        for (int k = 0; k < icache_pkg::LINE_WORDS; k++)
        begin
            line[k*icache_pkg::WORD_W +: icache_pkg::WORD_W] = (base | k) ^ 32'hA500_0000;
        end
        return line;
    endfunction

    // L2 model answering 1 to 6 cycles after a request once enabled
    initial
    begin : l2_model
        icache_pkg::l2_addr_t pend_addr;
        int                   wait_left;
        logic                 pending;
        fill_valid = 1'b0;
        fill_data  = '0;
        pending    = 1'b0;
        wait_left  = 0;
        pend_addr  = '0;
        req_count  = 0;
        forever
        begin
            @(posedge CLK);
            #1;
            fill_valid = 1'b0;
            if (RST)
            begin
                pending = 1'b0;
            end
            else if (l2_req)
            begin
                req_count++;
                pend_addr = l2_addr;
                wait_left = 1 + ($unsigned($random(seed)) % 6);
                pending   = 1'b1;
            end
            else if (pending && l2_enable)
            begin
                wait_left--;
                if (wait_left == 0)
                begin
                    fill_data  = model_line(pend_addr);
                    fill_valid = 1'b1;
                    pending    = 1'b0;
                end
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    function automatic row_t make_row(input icache_pkg::addr_t a, input logic fl,
                                      input logic ms, input logic sv);
        row_t r;
        r.addr  = a;
        r.flush = fl;
        r.miss  = ms;
        r.serve = sv;
        return r;
    endfunction

    // Lines 0x1040 and 0x9040 share index 2 and line 0x2007E0 sits at index 63
    task automatic build_table();
        rows.push_back(make_row(32'h0000_1044, 1'b0, 1'b1, 1'b1));
        for (int k = 0; k < icache_pkg::LINE_WORDS; k++)
        begin
            rows.push_back(make_row(32'h0000_1040 + 4 * k, 1'b0, 1'b0, 1'b0));
        end
        // Conflicting tag at the same index with a stalled L2
        rows.push_back(make_row(32'h0000_9040, 1'b0, 1'b1, 1'b0));
        rows.push_back(make_row(32'h0000_905C, 1'b0, 1'b0, 1'b0));
        rows.push_back(make_row(32'h0000_1040, 1'b0, 1'b1, 1'b1));
        rows.push_back(make_row(32'h0000_1048, 1'b0, 1'b0, 1'b0));
        rows.push_back(make_row(32'h0020_07E0, 1'b0, 1'b1, 1'b1));
        rows.push_back(make_row(32'h0020_07F0, 1'b0, 1'b0, 1'b0));
        rows.push_back(make_row(32'h0000_1054, 1'b0, 1'b0, 1'b0));
        // Both lines miss again after the flush
        rows.push_back(make_row(32'h0000_104C, 1'b1, 1'b1, 1'b1));
        rows.push_back(make_row(32'h0020_07E0, 1'b0, 1'b1, 1'b1));
        rows.push_back(make_row(32'h0000_1058, 1'b0, 1'b0, 1'b0));
    endtask

    task automatic apply_row(input row_t r);
        int cycles;
        int start;
        if (r.flush)
        begin
            @(posedge CLK);
            #1;
            addr_valid = 1'b0;
            flush      = 1'b1;
        end
        @(posedge CLK);
        #1;
        flush      = 1'b0;
        addr       = r.addr;
        addr_valid = 1'b1;
        l2_enable  = r.serve;
        #1;
        start = req_count;
        check_value("cache_ready", {31'b0, !r.miss}, {31'b0, cache_ready});
        if (r.miss)
        begin
            cycles = 0;
            while (req_count == start && cycles < 50)
            begin
                @(posedge CLK);
                #2;
                cycles++;
            end
            assert (req_count != start)
            else
            begin
                $display("Timeout while waiting for l2_req at address %h", r.addr);
                timeouts++;
            end
            check_value("l2_addr", r.addr >> icache_pkg::OFFSET_W, l2_addr);
            if (!r.serve)
            begin
                repeat (12)
                begin
                    @(posedge CLK);
                    #2;
                    check_value("cache_ready", 32'h0, {31'b0, cache_ready});
                end
                l2_enable = 1'b1;
            end
            cycles = 0;
            while (!cache_ready && cycles < 50)
            begin
                @(posedge CLK);
                #2;
                cycles++;
            end
            assert (cache_ready)
            else
            begin
                $display("Timeout while waiting for cache_ready at address %h", r.addr);
                timeouts++;
            end
        end
        check_value("data", expected_word(r.addr), data);
        // One request per miss and none for a hit
        @(posedge CLK);
        #2;
        check_value("l2_req pulses", {31'b0, r.miss}, req_count - start);
    endtask

    initial
    begin
        icache_pkg::addr_t a;
        seed       = 32'h3420;
        errors     = 0;
        timeouts   = 0;
        l2_enable  = 1'b0;
        RST        = 1'b1;
        flush      = 1'b0;
        addr       = '0;
        addr_valid = 1'b0;
        build_table();

        repeat (3) @(posedge CLK);
        #1;
        RST = 1'b0;

        // Every index reads empty after reset
        for (int i = 0; i < icache_pkg::DEPTH; i++)
        begin
            @(posedge CLK);
            #1;
            a = $random(seed);
            a[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W] = icache_pkg::index_t'(i);
            addr = a;
            #1;
            check_value("cache_ready", 32'h0, {31'b0, cache_ready});
            check_value("l2_req", 32'h0, {31'b0, l2_req});
        end

        foreach (rows[i])
        begin
            apply_row(rows[i]);
        end

        @(posedge CLK);
        #1;
        addr_valid = 1'b0;
        repeat (4) @(posedge CLK);

        $display("Checks done with %0d value errors, %0d timeouts, %0d assertion failures",
                 errors, timeouts, icache_top_i.refill_ctrl_i.icache_chk_i.assert_fails);
        if (errors == 0 && timeouts == 0 &&
            icache_top_i.refill_ctrl_i.icache_chk_i.assert_fails == 0)
        begin
            $display("** PASS **");
        end
        else
        begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
